// ==== dmacPkg.sv ====
// Data widths, register map, control/memory structs and FSM state types for the SCSI DMA controller
package dmacPkg;

    typedef logic [7:0]  ByteT;     // One SCSI data byte
    typedef logic [31:0] WordT;     // Longword on the memory bus and in the FIFO
    typedef logic [31:0] AddrT;     // Memory byte address
    typedef logic [15:0] CountT;    // Longword count
    typedef logic [1:0]  RegAddrT;  // Register select

    // Register map
    localparam RegAddrT RegCtrl   = 2'd0;
    localparam RegAddrT RegAddr   = 2'd1;
    localparam RegAddrT RegCount  = 2'd2;
    localparam RegAddrT RegStatus = 2'd3;

    // Bit positions inside the control and status registers
    localparam int CtrlEnableBit = 0;
    localparam int CtrlIntEnBit  = 1;
    localparam int StatusDoneBit = 0;  // Write 1 to clear
    localparam int StatusBusyBit = 1;

    // CPU register access
    typedef struct packed {
        logic    write;
        RegAddrT sel;
        WordT    wdata;
    } regReqT;

    // Transfer setup seen by the port and the bus master
    typedef struct packed {
        logic  enable;
        AddrT  startAddr;
        CountT count;
    } dmaCtrlT;

    // One memory write
    typedef struct packed {
        AddrT addr;
        WordT data;
    } memReqT;

    typedef enum logic {
        PortIdle,
        PortAck
    } portStateT;

    typedef enum logic [1:0] {
        MasterIdle,
        MasterRequest,
        MasterTransfer
    } masterStateT;

endpackage

// ==== dmacRegisters.sv ====
// CPU register block: control, address, count and status registers, start pulse and interrupt
`timescale 1ns/1ps

module dmacRegisters (
    input  logic             QnCPUCLK,
    input  logic             reset_i,
    input  logic             regValid_i,
    input  dmacPkg::regReqT  regReq_i,
    input  logic             xferDone_i,
    output dmacPkg::WordT    regRdata_o,
    output logic             regRdValid_o,
    output dmacPkg::dmaCtrlT dmaCtrl_o,
    output logic             start_o,
    output logic             int_o
);
    import dmacPkg::*;

    logic  ctrlEnable;
    logic  ctrlIntEn;
    AddrT  startAddr;
    CountT xferCount;
    logic  statusDone;
    logic  statusBusy;
    logic  wrStrobe;
    logic  rdStrobe;
    WordT  rdMux;

    assign wrStrobe = regValid_i & regReq_i.write;
    assign rdStrobe = regValid_i & ~regReq_i.write;

    // Read data select, registered below
    always_comb begin
        rdMux = '0;
        case (regReq_i.sel)
            RegCtrl: begin
                rdMux[CtrlEnableBit] = ctrlEnable;
                rdMux[CtrlIntEnBit]  = ctrlIntEn;
            end
            RegAddr:  rdMux = startAddr;
            RegCount: rdMux = WordT'(xferCount);
            RegStatus: begin
                rdMux[StatusDoneBit] = statusDone;
                rdMux[StatusBusyBit] = statusBusy;
            end
        endcase
    end

    always_ff @(posedge QnCPUCLK) begin
        if (reset_i) begin
            ctrlEnable   <= 1'b0;
            ctrlIntEn    <= 1'b0;
            startAddr    <= '0;
            xferCount    <= '0;
            statusDone   <= 1'b0;
            statusBusy   <= 1'b0;
            start_o      <= 1'b0;
            regRdata_o   <= '0;
            regRdValid_o <= 1'b0;
        end else begin
            start_o      <= 1'b0;
            regRdValid_o <= rdStrobe;  // Data valid one cycle after the request
            if (rdStrobe) begin
                regRdata_o <= rdMux;
            end
            if (wrStrobe) begin
                case (regReq_i.sel)
                    RegCtrl: begin
                        ctrlEnable <= regReq_i.wdata[CtrlEnableBit];
                        ctrlIntEn  <= regReq_i.wdata[CtrlIntEnBit];
                        if (regReq_i.wdata[CtrlEnableBit]) begin
                            statusBusy <= 1'b1;
                            start_o    <= 1'b1;  // Master loads address and count
                        end
                    end
                    RegAddr:  startAddr <= regReq_i.wdata;
                    RegCount: xferCount <= regReq_i.wdata[$bits(CountT)-1:0];
                    RegStatus: begin
                        if (regReq_i.wdata[StatusDoneBit]) begin
                            statusDone <= 1'b0;
                        end
                    end
                endcase
            end
            // Completion wins over a same-cycle write
            if (xferDone_i) begin
                statusDone <= 1'b1;
                statusBusy <= 1'b0;
                ctrlEnable <= 1'b0;
            end
        end
    end

    assign dmaCtrl_o = '{enable: ctrlEnable, startAddr: startAddr, count: xferCount};
    assign int_o     = statusDone & ctrlIntEn;  // Held until done is cleared

endmodule

// ==== scsiPortSm.sv ====
// SCSI DREQ/DACK handshake FSM feeding bytes to the packer
`timescale 1ns/1ps

module scsiPortSm (
    input  logic          QnCPUCLK,
    input  logic          reset_i,
    input  logic          enable_i,
    input  logic          scsiDreq_i,
    input  dmacPkg::ByteT scsiData_i,
    input  logic          fifoFull_i,
    output logic          scsiDack_o,
    output logic          byteValid_o,
    output dmacPkg::ByteT byte_o
);
    import dmacPkg::*;

    portStateT state;
    portStateT nextState;

    // Only answer a request when there is room for the longword
    always_comb begin
        nextState = state;
        case (state)
            PortIdle: begin
                if (enable_i && scsiDreq_i && !fifoFull_i) begin
                    nextState = PortAck;
                end
            end
            PortAck: nextState = PortIdle;  // Single-cycle DACK
            default: nextState = PortIdle;
        endcase
    end

    always_ff @(posedge QnCPUCLK) begin
        if (reset_i) begin
            state <= PortIdle;
        end else begin
            state <= nextState;
        end
    end

    assign scsiDack_o  = (state == PortAck);
    // Byte is taken at the edge that ends the DACK cycle
    assign byteValid_o = (state == PortAck);
    assign byte_o      = scsiData_i;

endmodule

// ==== dmaFifo.sv ====
// Byte packer and longword FIFO with full/empty flags
`timescale 1ns/1ps

module dmaFifo #(
    parameter int FifoDepth = 4
) (
    input  logic          QnCPUCLK,
    input  logic          reset_i,
    input  logic          start_i,
    input  logic          byteValid_i,
    input  dmacPkg::ByteT byte_i,
    input  logic          pop_i,
    output dmacPkg::WordT head_o,
    output logic          notEmpty_o,
    output logic          full_o
);
    import dmacPkg::*;

    localparam int PtrW   = $clog2(FifoDepth);
    localparam int LevelW = PtrW + 1;

    WordT              mem [FifoDepth];
    WordT              packReg;     // Earlier bytes of the current longword
    WordT              packedWord;
    logic [1:0]        byteOffset;
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [LevelW-1:0] level;
    logic              push;
    logic              pull;

    // First byte ends up in the top bits after four shifts
    assign packedWord = {packReg[23:0], byte_i};
    assign push       = byteValid_i & (byteOffset == 2'd3) & ~full_o;
    assign pull       = pop_i & notEmpty_o;

    assign head_o     = mem[rdPtr];
    assign notEmpty_o = (level != '0);
    assign full_o     = (level == LevelW'(FifoDepth));

    always_ff @(posedge QnCPUCLK) begin
        if (reset_i || start_i) begin
            byteOffset <= '0;
            wrPtr      <= '0;
            rdPtr      <= '0;
            level      <= '0;
        end else begin
            if (byteValid_i) begin
                byteOffset <= byteOffset + 2'd1;
            end
            if (push) begin
                wrPtr <= wrPtr + PtrW'(1);  // Wraps at FifoDepth
            end
            if (pull) begin
                rdPtr <= rdPtr + PtrW'(1);
            end
            if (push && !pull) begin
                level <= level + LevelW'(1);
            end else if (pull && !push) begin
                level <= level - LevelW'(1);
            end
        end
    end

    // Data path
    always_ff @(posedge QnCPUCLK) begin
        if (byteValid_i) begin
            packReg <= packedWord;
        end
        if (push) begin
            mem[wrPtr] <= packedWord;
        end
    end

endmodule

// ==== cpuBusMaster.sv ====
// Bus request/grant FSM and memory write sequencer with address and count tracking
`timescale 1ns/1ps

module cpuBusMaster (
    input  logic             QnCPUCLK,
    input  logic             reset_i,
    input  logic             start_i,
    input  dmacPkg::dmaCtrlT dmaCtrl_i,
    input  logic             fifoNotEmpty_i,
    input  dmacPkg::WordT    fifoHead_i,
    input  logic             busGrant_i,
    input  logic             memReady_i,
    output logic             pop_o,
    output logic             busReq_o,
    output logic             memValid_o,
    output dmacPkg::memReqT  memReq_o,
    output logic             xferDone_o
);
    import dmacPkg::*;

    masterStateT state;
    AddrT        workAddr;
    CountT       remaining;   // Longwords still to write
    logic        handshake;
    logic        lastWord;

    // Head word stays put until popped, so the request is held
    assign memValid_o = (state == MasterTransfer) & fifoNotEmpty_i;
    assign busReq_o   = (state == MasterRequest) | memValid_o;
    assign handshake  = memValid_o & memReady_i;
    assign pop_o      = handshake;
    assign lastWord   = (remaining == CountT'(1));
    assign memReq_o   = '{addr: workAddr, data: fifoHead_i};

    always_ff @(posedge QnCPUCLK) begin
        if (reset_i) begin
            state      <= MasterIdle;
            workAddr   <= '0;
            remaining  <= '0;
            xferDone_o <= 1'b0;
        end else begin
            // Zero count finishes straight away
            xferDone_o <= (handshake & lastWord) | (start_i & (dmaCtrl_i.count == '0));
            if (start_i) begin
                workAddr  <= dmaCtrl_i.startAddr;
                remaining <= dmaCtrl_i.count;
                state     <= MasterIdle;
            end else begin
                case (state)
                    MasterIdle: begin
                        if (dmaCtrl_i.enable && (remaining != '0) && fifoNotEmpty_i) begin
                            state <= MasterRequest;
                        end
                    end
                    MasterRequest: begin
                        if (busGrant_i) begin
                            state <= MasterTransfer;
                        end
                    end
                    MasterTransfer: begin
                        if (handshake) begin
                            workAddr  <= workAddr + AddrT'(4);
                            remaining <= remaining - CountT'(1);
                            if (lastWord) begin
                                state <= MasterIdle;
                            end
                        end else if (!fifoNotEmpty_i) begin
                            state <= MasterIdle;  // Give the bus back until data arrives
                        end
                    end
                    default: state <= MasterIdle;
                endcase
            end
        end
    end

endmodule

// ==== dmacTop.sv ====
// SCSI DMA controller top level: registers, SCSI port, packing FIFO and bus master
`timescale 1ns/1ps

module dmacTop #(
    parameter int FifoDepth = 4
) (
    input  logic            QnCPUCLK,
    input  logic            reset_i,
    // CPU register port
    input  logic            regValid_i,
    input  dmacPkg::regReqT regReq_i,
    output dmacPkg::WordT   regRdata_o,
    output logic            regRdValid_o,
    output logic            int_o,
    // SCSI peripheral
    input  logic            scsiDreq_i,
    input  dmacPkg::ByteT   scsiData_i,
    output logic            scsiDack_o,
    // System bus
    output logic            busReq_o,
    input  logic            busGrant_i,
    output logic            memValid_o,
    output dmacPkg::memReqT memReq_o,
    input  logic            memReady_i
);
    import dmacPkg::*;

    dmaCtrlT dmaCtrl;
    logic    start;
    logic    xferDone;
    logic    byteValid;
    ByteT    scsiByte;
    WordT    fifoHead;
    logic    fifoNotEmpty;
    logic    fifoFull;
    logic    pop;

    dmacRegisters uRegisters (
        .QnCPUCLK     (QnCPUCLK    ),
        .reset_i      (reset_i     ),
        .regValid_i   (regValid_i  ),
        .regReq_i     (regReq_i    ),
        .xferDone_i   (xferDone    ),
        .regRdata_o   (regRdata_o  ),
        .regRdValid_o (regRdValid_o),
        .dmaCtrl_o    (dmaCtrl     ),
        .start_o      (start       ),
        .int_o        (int_o       )
    );

    scsiPortSm uScsiPort (
        .QnCPUCLK    (QnCPUCLK      ),
        .reset_i     (reset_i       ),
        .enable_i    (dmaCtrl.enable),  // Port runs only while the transfer is on
        .scsiDreq_i  (scsiDreq_i    ),
        .scsiData_i  (scsiData_i    ),
        .fifoFull_i  (fifoFull      ),
        .scsiDack_o  (scsiDack_o    ),
        .byteValid_o (byteValid     ),
        .byte_o      (scsiByte      )
    );

    dmaFifo #(
        .FifoDepth (FifoDepth)
    ) uFifo (
        .QnCPUCLK    (QnCPUCLK    ),
        .reset_i     (reset_i     ),
        .start_i     (start       ),
        .byteValid_i (byteValid   ),
        .byte_i      (scsiByte    ),
        .pop_i       (pop         ),
        .head_o      (fifoHead    ),
        .notEmpty_o  (fifoNotEmpty),
        .full_o      (fifoFull    )
    );

    cpuBusMaster uBusMaster (
        .QnCPUCLK       (QnCPUCLK    ),
        .reset_i        (reset_i     ),
        .start_i        (start       ),
        .dmaCtrl_i      (dmaCtrl     ),
        .fifoNotEmpty_i (fifoNotEmpty),
        .fifoHead_i     (fifoHead    ),
        .busGrant_i     (busGrant_i  ),
        .memReady_i     (memReady_i  ),
        .pop_o          (pop         ),
        .busReq_o       (busReq_o    ),
        .memValid_o     (memValid_o  ),
        .memReq_o       (memReq_o    ),
        .xferDone_o     (xferDone    )
    );

endmodule

// ==== dmacTop_props.sv ====
// Bound assertions on memory handshake, bus grant, DACK width and reset state of dmacTop
`timescale 1ns/1ps

module dmacTopProps (
    input logic            QnCPUCLK,
    input logic            reset_i,
    input logic            memValid_o,
    input logic            memReady_i,
    input dmacPkg::memReqT memReq_o,
    input logic            busGrant_i,
    input logic            scsiDack_o,
    input logic            busReq_o,
    input logic            int_o
);
    int assertFails = 0;  // Failed assertions so far

    memHeld: assert property (@(posedge QnCPUCLK) disable iff (reset_i)
        (memValid_o && !memReady_i) |=> (memValid_o && $stable(memReq_o)))
        else begin
            assertFails++;
            $error("Memory request changed before memReady");
        end

    memGranted: assert property (@(posedge QnCPUCLK) disable iff (reset_i)
        memValid_o |-> busGrant_i)
        else begin
            assertFails++;
            $error("Memory write without bus grant");
        end

    dackSingle: assert property (@(posedge QnCPUCLK) disable iff (reset_i)
        scsiDack_o |=> !scsiDack_o)
        else begin
            assertFails++;
            $error("DACK held for two cycles");
        end

    // First cycle out of reset
    resetQuiet: assert property (@(posedge QnCPUCLK)
        $fell(reset_i) |-> (!busReq_o && !int_o))
        else begin
            assertFails++;
            $error("Bus request or interrupt active right after reset");
        end

endmodule

bind dmacTop dmacTopProps uProps (
    .QnCPUCLK   (QnCPUCLK  ),
    .reset_i    (reset_i   ),
    .memValid_o (memValid_o),
    .memReady_i (memReady_i),
    .memReq_o   (memReq_o  ),
    .busGrant_i (busGrant_i),
    .scsiDack_o (scsiDack_o),
    .busReq_o   (busReq_o  ),
    .int_o      (int_o     )
);

// ==== tbDmacTop.sv ====
// Testbench for the SCSI DMA controller: pattern-driven CPU, SCSI, grant and memory models with checks
`timescale 1ns/1ps

module tbDmacTop;
    import dmacPkg::*;

    localparam int FifoDepth = 4;  // Must match the value given to the DUT

    logic            QnCPUCLK = 1'b0;
    logic            reset_i;
    logic            regValid_i;
    regReqT          regReq_i;
    WordT            regRdata_o;
    logic            regRdValid_o;
    logic            int_o;
    logic            scsiDreq_i;
    ByteT            scsiData_i;
    logic            scsiDack_o;
    logic            busReq_o;
    logic            busGrant_i;
    logic            memValid_o;
    memReqT          memReq_o;
    logic            memReady_i;

    WordT   patMem [0:255];
    ByteT   byteQ [$];     // Bytes still to offer on the SCSI port
    memReqT expQ [$];      // Memory writes still expected
    int     dackCount  = 0;
    int     cycleCount = 0;
    int     cycleLimit = 0;
    int     grantWait  = 0;
    int     gap        = 0;
    logic   byteTaken  = 1'b0;
    logic   holdReady  = 1'b0;

    dmacTop #(
        .FifoDepth (FifoDepth)
    ) UUT (
        .QnCPUCLK     (QnCPUCLK    ),
        .reset_i      (reset_i     ),
        .regValid_i   (regValid_i  ),
        .regReq_i     (regReq_i    ),
        .regRdata_o   (regRdata_o  ),
        .regRdValid_o (regRdValid_o),
        .int_o        (int_o       ),
        .scsiDreq_i   (scsiDreq_i  ),
        .scsiData_i   (scsiData_i  ),
        .scsiDack_o   (scsiDack_o  ),
        .busReq_o     (busReq_o    ),
        .busGrant_i   (busGrant_i  ),
        .memValid_o   (memValid_o  ),
        .memReq_o     (memReq_o    ),
        .memReady_i   (memReady_i  )
    );

    always #20 QnCPUCLK = ~QnCPUCLK;

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic checkWord(input WordT got, input WordT exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkMemReq(input memReqT got, input memReqT exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERROR %0t: %s at %h data %h, expected %h data %h", $time, what,
                              got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERROR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic writeReg(input RegAddrT sel, input WordT data);
        @(negedge QnCPUCLK);
        regValid_i = 1'b1;
        regReq_i   = '{write: 1'b1, sel: sel, wdata: data};
        @(negedge QnCPUCLK);  // Write has taken effect here
        regValid_i = 1'b0;
        regReq_i   = '0;
    endtask

    task automatic readReg(input RegAddrT sel, output WordT data);
        @(negedge QnCPUCLK);
        regValid_i = 1'b1;
        regReq_i   = '{write: 1'b0, sel: sel, wdata: '0};
        @(negedge QnCPUCLK);
        regValid_i = 1'b0;
        regReq_i   = '0;
        checkBit(regRdValid_o, 1'b1, "read data valid one cycle after request");
        data = regRdata_o;
    endtask

    // SCSI peripheral that moves on after the rising edge seen under DACK
    always @(negedge QnCPUCLK) begin
        if (byteTaken) begin
            void'(byteQ.pop_front());
            byteTaken = 1'b0;
            gap       = $urandom % 3;
        end
        if (scsiDack_o) begin
            byteTaken = 1'b1;
            dackCount++;
        end
        if (!byteTaken) begin
            if (gap > 0) begin
                scsiDreq_i = 1'b0;
                gap--;
            end else if (byteQ.size() != 0) begin
                scsiDreq_i = 1'b1;
                scsiData_i = byteQ[0];
            end else begin
                scsiDreq_i = 1'b0;
            end
        end
    end

    // Bus arbiter and memory model
    always @(negedge QnCPUCLK) begin
        if (!busReq_o) begin
            busGrant_i = 1'b0;
            grantWait  = $urandom % 4;
        end else if (!busGrant_i) begin
            if (grantWait == 0) begin
                busGrant_i = 1'b1;
            end else begin
                grantWait--;
            end
        end
        memReady_i = holdReady ? 1'b0 : (($urandom % 4) != 0);
        // Handshake completes at the next rising edge
        if (memValid_o && memReady_i) begin
            if (expQ.size() == 0) begin
                stopRun("A memory write arrived when no more writes were expected");
            end else begin
                checkMemReq(memReq_o, expQ.pop_front(), "memory write");
            end
        end
    end

    always @(posedge QnCPUCLK) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            stopRun($sformatf("Timeout: the tests did not finish within %0d cycles", cycleLimit));
        end
    end

    always @(negedge QnCPUCLK) begin
        if (UUT.uProps.assertFails != 0) begin
            stopRun($sformatf("%0d bus or handshake assertions failed", UUT.uProps.assertFails));
        end
    end

    task automatic runTest(input int first);
        AddrT  startAddr;
        CountT count;
        logic  intEn;
        logic  throttle;
        WordT  rd;
        WordT  word;
        int    dackBase;
        int    n;
        int    b;
        startAddr = patMem[first];
        count     = CountT'(patMem[first + 1]);
        intEn     = patMem[first + 2][0];
        throttle  = (count > FifoDepth);  // Enough data to fill the FIFO
        writeReg(RegAddr, startAddr);
        writeReg(RegCount, WordT'(count));
        writeReg(RegCtrl, WordT'({intEn, 1'b0}));
        readReg(RegAddr, rd);
        checkWord(rd, startAddr, "address readback");
        readReg(RegCount, rd);
        checkWord(rd, WordT'(count), "count readback");
        @(posedge QnCPUCLK);
        for (n = 0; n < count; n++) begin
            word = patMem[first + 3 + n];
            expQ.push_back(memReqT'{addr: startAddr + AddrT'(4 * n), data: word});
            for (b = 3; b >= 0; b--) begin
                byteQ.push_back(word[8 * b +: 8]);  // Top byte goes first
            end
        end
        // DREQ is up but the DMA is still off
        repeat (12) begin
            @(negedge QnCPUCLK);
            checkBit(scsiDack_o, 1'b0, "DACK with DMA disabled");
            checkBit(busReq_o, 1'b0, "bus request with DMA disabled");
        end
        holdReady = throttle;
        dackBase  = dackCount;
        writeReg(RegCtrl, WordT'({intEn, 1'b1}));
        readReg(RegStatus, rd);
        checkBit(rd[StatusBusyBit], 1'b1, "status busy after enable");
        checkBit(rd[StatusDoneBit], 1'b0, "status done after enable");
        if (throttle) begin
            while (dackCount - dackBase < 4 * FifoDepth) begin
                @(posedge QnCPUCLK);
            end
            repeat (20) @(posedge QnCPUCLK);
            checkWord(WordT'(dackCount - dackBase), WordT'(4 * FifoDepth),
                      "DACK count with memory stalled");
            checkWord(WordT'(expQ.size()), WordT'(count), "writes pending with memory stalled");
            holdReady = 1'b0;
        end
        while (expQ.size() != 0) begin
            @(posedge QnCPUCLK);
        end
        do begin
            readReg(RegStatus, rd);
        end while (!rd[StatusDoneBit]);
        checkBit(rd[StatusBusyBit], 1'b0, "status busy at completion");
        checkBit(int_o, intEn, "interrupt at completion");
        checkBit(busReq_o, 1'b0, "bus request after completion");
        readReg(RegCtrl, rd);
        checkWord(rd, WordT'({intEn, 1'b0}), "control register after completion");
        writeReg(RegStatus, WordT'(1));
        checkBit(int_o, 1'b0, "interrupt after clearing done");
    endtask

    initial begin
        int idx;
        int numTests;
        int t;
        void'($urandom(95807));
        reset_i    = 1'b1;
        regValid_i = 1'b0;
        regReq_i   = '0;
        scsiDreq_i = 1'b0;
        scsiData_i = '0;
        busGrant_i = 1'b0;
        memReady_i = 1'b0;
        $readmemh("dmacPatterns.txt", patMem);
        if ($isunknown(patMem[0])) begin
            stopRun("Could not read the test patterns from dmacPatterns.txt");
        end
        numTests = patMem[0];
        idx      = 1;
        for (t = 0; t < numTests; t++) begin
            cycleLimit += 200 + 40 * int'(patMem[idx + 1]);
            idx += 3 + int'(patMem[idx + 1]);
        end
        repeat (3) @(posedge QnCPUCLK);
        @(negedge QnCPUCLK);
        reset_i = 1'b0;
        idx     = 1;
        for (t = 0; t < numTests; t++) begin
            runTest(idx);
            idx += 3 + int'(patMem[idx + 1]);
        end
        repeat (4) @(posedge QnCPUCLK);
        if (UUT.uProps.assertFails == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stopRun($sformatf("%0d bus or handshake assertions failed during the run",
                              UUT.uProps.assertFails));
        end
    end

endmodule

// ==== dmacPatterns.txt ====
// First value is the number of tests; each test has start address, longword count, interrupt enable
// followed by its longwords, one per line, whose top byte is sent first on the SCSI port
00000003
00001000 00000003 00000001
11223344
A5C3E70F
DEADBEEF
00020040 00000002 00000000
01020304
FEDCBA98
80000FF0 00000007 00000001
0F1E2D3C
4B5A6978
8796A5B4
C3D2E1F0
00FF00FF
13579BDF
2468ACE0

// ==== flist.f ====
dmacPkg.sv
dmacRegisters.sv
scsiPortSm.sv
dmaFifo.sv
cpuBusMaster.sv
dmacTop.sv
dmacTop_props.sv
tbDmacTop.sv
